/* hw/coproc_settings.svh */
// string-match coprocessor sizes shared by the package and the RTL stages
`ifndef COPROC_SETTINGS_SVH
`define COPROC_SETTINGS_SVH

// one text character
`define CHAR_WIDTH 8

// memory bus word, holds two characters
`define MEM_WIDTH 16

// word address into the text memory
`define MEM_ADDR_WIDTH 11

// characters packed in one memory word, little-endian
`define CHARS_PER_WORD 2

// low pointer bits that pick the character inside a word
`define CHAR_OFFSET_BITS 1

// character pointer is the word address followed by the offset
`define PTR_WIDTH 12

// longest literal pattern the shift-and engine can hold
`define PATTERN_CHARS 4

`endif

/* hw/coproc_pkg.sv */
// string-match coprocessor types for characters, memory words, pointers and control
`include "coproc_settings.svh"

package coproc_pkg;

    // one character of the text stream
    typedef logic [`CHAR_WIDTH-1:0] char_t;

    // raw memory word as returned by the text memory
    typedef logic [`MEM_WIDTH-1:0] mem_word_t;

    // word address on the memory request bus
    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // character pointer, word address in the upper bits
    typedef logic [`PTR_WIDTH-1:0] char_ptr_t;

    // packed pattern, character 0 in the low byte
    typedef logic [`PATTERN_CHARS*`CHAR_WIDTH-1:0] pattern_t;

    // pattern length, 1 to PATTERN_CHARS
    typedef logic [$clog2(`PATTERN_CHARS+1)-1:0] pattern_len_t;

    // one bit per pattern prefix that matches so far
    typedef logic [`PATTERN_CHARS-1:0] match_state_t;

    // supervising FSM of the coprocessor
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_DONE_ACCEPT,
        CTRL_DONE_REJECT,
        CTRL_ERROR
    } ctrl_state_t;

endpackage

/* hw/text_fetcher.sv */
// text fetcher: word reads from memory, one-word buffer and a character stream with last flag
`include "coproc_settings.svh"

module text_fetcher
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush,
    input  logic                  job_start,
    input  coproc_pkg::char_ptr_t start_ptr,
    input  coproc_pkg::char_ptr_t end_ptr,
    input  logic                  memory_ready,
    input  coproc_pkg::mem_word_t memory_data,
    output logic                  memory_valid,
    output coproc_pkg::mem_addr_t memory_addr,
    output logic                  char_valid,
    output coproc_pkg::char_t     char_data,
    output logic                  char_last
);

    // control flags
    logic                  req_valid;
    logic                  rd_pending;
    logic                  buf_valid;

    // job pointers and the word buffer
    coproc_pkg::char_ptr_t end_ptr_q;
    coproc_pkg::char_ptr_t cur_ptr;
    coproc_pkg::mem_addr_t fetch_addr;
    coproc_pkg::mem_word_t buf_word;

    // derived
    logic                  mem_accept;
    logic                  more_words;
    logic [`CHAR_OFFSET_BITS-1:0] cur_off;
    coproc_pkg::mem_word_t src_word;

    assign mem_accept = req_valid && memory_ready;

    // request stays put until the memory takes it
    assign memory_valid = req_valid;
    assign memory_addr  = fetch_addr;

    // word being read is not yet the word holding end_ptr
    assign more_words = fetch_addr != end_ptr_q[`PTR_WIDTH-1:`CHAR_OFFSET_BITS];

    assign cur_off = cur_ptr[`CHAR_OFFSET_BITS-1:0];

    // data cycle takes the bus directly, otherwise the buffer feeds the stream
    assign src_word   = rd_pending ? memory_data : buf_word;
    assign char_valid = rd_pending || buf_valid;
    assign char_data  = src_word[cur_off*`CHAR_WIDTH +: `CHAR_WIDTH];
    assign char_last  = char_valid && (cur_ptr == end_ptr_q);

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            req_valid  <= 1'b0;
            rd_pending <= 1'b0;
            buf_valid  <= 1'b0;
        end
        else if (job_start)
        begin
            // first word goes out on the next cycle
            req_valid  <= 1'b1;
            rd_pending <= 1'b0;
            buf_valid  <= 1'b0;
        end
        else
        begin
            // data shows up exactly one cycle after acceptance
            rd_pending <= mem_accept;
            if (mem_accept)
            begin
                req_valid <= 1'b0;
            end
            else if (rd_pending)
            begin
                // next word is requested while the buffer drains
                req_valid <= more_words && !char_last;
            end
            // keep buffering while characters remain in this word
            buf_valid <= char_valid && !char_last && !(&cur_off);
        end
    end

    // pointers and buffer, only meaningful while the flags above are set
    always_ff @(posedge clk)
    begin
        if (job_start)
        begin
            end_ptr_q  <= end_ptr;
            cur_ptr    <= start_ptr;
            fetch_addr <= start_ptr[`PTR_WIDTH-1:`CHAR_OFFSET_BITS];
        end
        else
        begin
            if (rd_pending)
            begin
                // word is in hand, so move the fetch address on
                fetch_addr <= fetch_addr + 1'b1;
                buf_word   <= memory_data;
            end
            if (char_valid)
            begin
                cur_ptr <= cur_ptr + 1'b1;
            end
        end
    end

endmodule

/* hw/shift_and_matcher.sv */
// shift-and matcher: bit-parallel search for a literal pattern of up to four characters
`include "coproc_settings.svh"

module shift_and_matcher
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     job_start,
    input  coproc_pkg::pattern_t     pattern,
    input  coproc_pkg::pattern_len_t pattern_len,
    input  logic                     char_valid,
    input  coproc_pkg::char_t        char_data,
    input  logic                     char_last,
    output logic                     hit_valid,
    output logic                     hit,
    output logic                     hit_last
);

    // pattern held for the whole job
    coproc_pkg::pattern_t     pattern_q;
    coproc_pkg::pattern_len_t pattern_len_q;

    // partial-match vector, bit i set when chars 0..i end at the last char
    coproc_pkg::match_state_t match_state;
    coproc_pkg::match_state_t next_state;
    coproc_pkg::match_state_t char_mask;
    coproc_pkg::match_state_t len_sel;

    always_comb
    begin
        for (int i = 0; i < `PATTERN_CHARS; i++)
        begin
            // which pattern positions equal the incoming char
            char_mask[i] = char_data == pattern_q[i*`CHAR_WIDTH +: `CHAR_WIDTH];
            // one-hot pick of the final pattern position
            len_sel[i]   = pattern_len_q == coproc_pkg::pattern_len_t'(i + 1);
        end
        // shift in a one so a fresh match can start at every char
        next_state = {match_state[`PATTERN_CHARS-2:0], 1'b1} & char_mask;
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush || job_start)
        begin
            match_state <= '0;
            hit_valid   <= 1'b0;
            hit         <= 1'b0;
            hit_last    <= 1'b0;
        end
        else
        begin
            // output stage follows char_valid by one cycle
            hit_valid <= char_valid;
            if (char_valid)
            begin
                match_state <= next_state;
                hit         <= |(next_state & len_sel);
                hit_last    <= char_last;
            end
        end
    end

    // latched in the handshake cycle, the host bus moves on afterwards
    always_ff @(posedge clk)
    begin
        if (job_start)
        begin
            pattern_q     <= pattern;
            pattern_len_q <= pattern_len;
        end
    end

endmodule

/* hw/job_control.sv */
// job control: host handshake, pointer checks and the supervising FSM
`include "coproc_settings.svh"

module job_control
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid,
    input  coproc_pkg::char_ptr_t start_ptr,
    input  coproc_pkg::char_ptr_t end_ptr,
    input  logic                  hit_valid,
    input  logic                  hit,
    input  logic                  hit_last,
    output logic                  ready,
    output logic                  job_start,
    output logic                  flush,
    output logic                  done,
    output logic                  accept,
    output logic                  error
);

    coproc_pkg::ctrl_state_t cur_state;
    coproc_pkg::ctrl_state_t next_state;

    // start must sit on a word boundary, end must not precede start
    logic bad_job;

    assign bad_job = (start_ptr[`CHAR_OFFSET_BITS-1:0] != '0) || (end_ptr < start_ptr);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cur_state <= coproc_pkg::CTRL_IDLE;
        end
        else
        begin
            cur_state <= next_state;
        end
    end

    always_comb
    begin
        next_state = cur_state;
        ready      = 1'b0;
        job_start  = 1'b0;
        flush      = 1'b0;
        done       = 1'b0;
        accept     = 1'b0;
        error      = 1'b0;
        case (cur_state)
            coproc_pkg::CTRL_IDLE:
            begin
                ready = 1'b1;
                if (valid)
                begin
                    if (bad_job)
                    begin
                        // no start pulse, the error is sticky
                        next_state = coproc_pkg::CTRL_ERROR;
                    end
                    else
                    begin
                        job_start  = 1'b1;
                        next_state = coproc_pkg::CTRL_RUN;
                    end
                end
            end
            coproc_pkg::CTRL_RUN:
            begin
                // a hit wins over the end of string on the same char
                if (hit_valid && hit)
                begin
                    next_state = coproc_pkg::CTRL_DONE_ACCEPT;
                end
                else if (hit_valid && hit_last)
                begin
                    next_state = coproc_pkg::CTRL_DONE_REJECT;
                end
            end
            coproc_pkg::CTRL_DONE_ACCEPT:
            begin
                done       = 1'b1;
                accept     = 1'b1;
                // drop whatever the fetcher and matcher still hold
                flush      = 1'b1;
                next_state = coproc_pkg::CTRL_IDLE;
            end
            coproc_pkg::CTRL_DONE_REJECT:
            begin
                done       = 1'b1;
                flush      = 1'b1;
                next_state = coproc_pkg::CTRL_IDLE;
            end
            coproc_pkg::CTRL_ERROR:
            begin
                // held here until reset
                error = 1'b1;
            end
            default:
            begin
                next_state = coproc_pkg::CTRL_IDLE;
            end
        endcase
    end

endmodule

/* hw/coprocessor_top.sv */
// string-match coprocessor top: fetcher, shift-and matcher and job control in a pipeline
module coprocessor_top
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     valid,
    input  coproc_pkg::char_ptr_t    start_ptr,
    input  coproc_pkg::char_ptr_t    end_ptr,
    input  coproc_pkg::pattern_t     pattern,
    input  coproc_pkg::pattern_len_t pattern_len,
    input  logic                     memory_ready,
    input  coproc_pkg::mem_word_t    memory_data,
    output logic                     ready,
    output logic                     memory_valid,
    output coproc_pkg::mem_addr_t    memory_addr,
    output logic                     done,
    output logic                     accept,
    output logic                     error
);

    // control to the datapath stages
    logic              job_start;
    logic              flush;

    // character stream, valid only
    logic              char_valid;
    coproc_pkg::char_t char_data;
    logic              char_last;

    // matcher results back to control
    logic              hit_valid;
    logic              hit;
    logic              hit_last;

    job_control u_job_control (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .start_ptr (start_ptr),
        .end_ptr   (end_ptr),
        .hit_valid (hit_valid),
        .hit       (hit),
        .hit_last  (hit_last),
        .ready     (ready),
        .job_start (job_start),
        .flush     (flush),
        .done      (done),
        .accept    (accept),
        .error     (error)
    );

    text_fetcher u_text_fetcher (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .job_start    (job_start),
        .start_ptr    (start_ptr),
        .end_ptr      (end_ptr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .char_valid   (char_valid),
        .char_data    (char_data),
        .char_last    (char_last)
    );

    shift_and_matcher u_shift_and_matcher (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .job_start   (job_start),
        .pattern     (pattern),
        .pattern_len (pattern_len),
        .char_valid  (char_valid),
        .char_data   (char_data),
        .char_last   (char_last),
        .hit_valid   (hit_valid),
        .hit         (hit),
        .hit_last    (hit_last)
    );

endmodule

/* verification/tb_coprocessor.sv */
// testbench for the string-match coprocessor with memory model, directed and random jobs and assertions
`include "coproc_settings.svh"

module tb_coprocessor;

    localparam int PERIOD       = 10;
    localparam int RESET_CYCLES = 4;
    localparam int MEM_WORDS    = 1 << `MEM_ADDR_WIDTH;
    localparam int MAX_STR      = 32;
    localparam int STALL_MARGIN = 8;
    localparam int NUM_RANDOM   = 40;
    // directed, random, invalid and recovery jobs
    localparam int NUM_JOBS     = 8 + NUM_RANDOM + 2 + 1;
    localparam int JOB_LIMIT    = MAX_STR * STALL_MARGIN;

    logic                     clk = 1'b0;
    logic                     rst = 1'b1;
    logic                     valid = 1'b0;
    coproc_pkg::char_ptr_t    start_ptr = '0;
    coproc_pkg::char_ptr_t    end_ptr = '0;
    coproc_pkg::pattern_t     pattern = '0;
    coproc_pkg::pattern_len_t pattern_len = '0;
    logic                     memory_ready = 1'b0;
    coproc_pkg::mem_word_t    memory_data = '0;
    logic                     ready;
    logic                     memory_valid;
    coproc_pkg::mem_addr_t    memory_addr;
    logic                     done;
    logic                     accept;
    logic                     error;

    // text memory and random source
    coproc_pkg::mem_word_t mem [0:MEM_WORDS-1];
    integer                seed = 32'h1816;
    logic                  stall_en = 1'b0;

    // expectations of the running job
    logic exp_accept = 1'b0;
    int   lo_word = 0;
    int   hi_word = MEM_WORDS - 1;

    // bookkeeping sampled on the falling edge
    int max_rd = -1;
    int done_count = 0;
    int good_jobs = 0;
    int errors = 0;

    coprocessor_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .start_ptr    (start_ptr),
        .end_ptr      (end_ptr),
        .pattern      (pattern),
        .pattern_len  (pattern_len),
        .memory_ready (memory_ready),
        .memory_data  (memory_data),
        .ready        (ready),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .done         (done),
        .accept       (accept),
        .error        (error)
    );

    always #(PERIOD / 2) clk = ~clk;

    // memory with one-cycle read latency and ready stalls in the random phase only
    always @(posedge clk)
    begin
        if (stall_en)
        begin
            memory_ready <= ($random(seed) & 3) != 0;
        end
        else
        begin
            memory_ready <= 1'b1;
        end
        if (memory_valid && memory_ready)
        begin
            memory_data <= mem[memory_addr];
        end
    end

    // highest word read in the current job is cleared at the handshake
    always @(negedge clk)
    begin
        if (valid && ready)
        begin
            max_rd <= -1;
        end
        else if (memory_valid && memory_ready && int'(memory_addr) > max_rd)
        begin
            max_rd <= int'(memory_addr);
        end
        if (done)
        begin
            done_count <= done_count + 1;
        end
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("FAILED at time %0t: %s", $time, msg);
    endtask

    // every reset leaves the block idle with no request out
    assert property (@(posedge clk)
        rst |=> (ready && !done && !accept && !error && !memory_valid))
        else report_mismatch("outputs not at reset values after reset");

    assert property (@(posedge clk) disable iff (rst) done |-> accept == exp_accept)
        else report_mismatch("accept differs from reference search");

    assert property (@(posedge clk) disable iff (rst) accept |-> done)
        else report_mismatch("accept high without done");

    assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else report_mismatch("done longer than one cycle");

    // request is held while stalled but the flush in the done cycle may drop it
    assert property (@(posedge clk) disable iff (rst)
        (memory_valid && !memory_ready && !done) |=> (memory_valid && $stable(memory_addr)))
        else report_mismatch("memory request changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        (memory_valid && memory_ready) |-> (memory_addr >= lo_word && memory_addr <= hi_word))
        else report_mismatch("read address outside the job's word range");

    // no reads between done and the next job
    assert property (@(posedge clk) disable iff (rst) ready |-> !memory_valid)
        else report_mismatch("memory request while idle");

    assert property (@(posedge clk) disable iff (rst) error |=> (error && !ready))
        else report_mismatch("error not held or ready raised in error");

    assert property (@(posedge clk) disable iff (rst) error |-> (!done && !memory_valid))
        else report_mismatch("activity in error state");

    function automatic coproc_pkg::char_t char_at(input int p);
        return mem[p >> 1][(p & 1) * `CHAR_WIDTH +: `CHAR_WIDTH];
    endfunction

    // pointer of the last char of the first match or -1 without a match
    function automatic int ref_match(input int s, input int e,
                                     input coproc_pkg::pattern_t p, input int l);
        logic ok;
        for (int q = s + l - 1; q <= e; q++)
        begin
            ok = 1'b1;
            for (int k = 0; k < l; k++)
            begin
                if (char_at(q - l + 1 + k) != p[k*`CHAR_WIDTH +: `CHAR_WIDTH])
                begin
                    ok = 1'b0;
                end
            end
            if (ok)
            begin
                return q;
            end
        end
        return -1;
    endfunction

    function automatic coproc_pkg::pattern_t make_pattern(input string s);
        coproc_pkg::pattern_t p;
        p = '0;
        for (int i = 0; i < s.len(); i++)
        begin
            p[i*`CHAR_WIDTH +: `CHAR_WIDTH] = s[i];
        end
        return p;
    endfunction

    task automatic put_string(input int p, input string s);
        for (int i = 0; i < s.len(); i++)
        begin
            mem[(p + i) >> 1][((p + i) & 1) * `CHAR_WIDTH +: `CHAR_WIDTH] = s[i];
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst   <= 1'b1;
        valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_job(input int s, input int e, input coproc_pkg::pattern_t p, input int l);
        int m;
        int cycles;
        m = ref_match(s, e, p, l);
        @(negedge clk);
        while (!ready) @(negedge clk);
        @(posedge clk);
        valid       <= 1'b1;
        start_ptr   <= coproc_pkg::char_ptr_t'(s);
        end_ptr     <= coproc_pkg::char_ptr_t'(e);
        pattern     <= p;
        pattern_len <= coproc_pkg::pattern_len_t'(l);
        exp_accept  <= m >= 0;
        lo_word     <= s >> 1;
        hi_word     <= e >> 1;
        // ready is high and the job is taken at this edge
        @(posedge clk);
        valid <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < JOB_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        good_jobs++;
        if (!done)
        begin
            errors++;
            $display("job from pointer %0d to %0d did not finish within %0d cycles",
                     s, e, JOB_LIMIT);
        end
        else
        begin
            // the read of the done cycle reaches the tracker one edge later
            @(negedge clk);
            if (m >= 0 && m < e)
            begin
                // one word goes out behind the match and one more when it hits on the buffered char
                assert (max_rd <= (m >> 1) + 1 + (m & 1))
                    else report_mismatch("reads went on past the matching word");
            end
        end
    endtask

    task automatic run_text(input int p, input string text, input string pat);
        put_string(p, text);
        run_job(p, p + text.len() - 1, make_pattern(pat), pat.len());
    endtask

    task automatic run_bad_job(input int s, input int e);
        int cycles;
        @(negedge clk);
        while (!ready) @(negedge clk);
        @(posedge clk);
        valid       <= 1'b1;
        start_ptr   <= coproc_pkg::char_ptr_t'(s);
        end_ptr     <= coproc_pkg::char_ptr_t'(e);
        pattern     <= make_pattern("a");
        pattern_len <= coproc_pkg::pattern_len_t'(1);
        cycles = 0;
        @(negedge clk);
        while (!error && cycles < JOB_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!error)
        begin
            errors++;
            $display("invalid job from pointer %0d to %0d raised no error", s, e);
        end
        // valid stays high and the block must stay locked
        repeat (8)
        begin
            @(negedge clk);
            assert (error && !ready && !done)
                else report_mismatch("error state not held");
        end
        apply_reset();
    endtask

    initial
    begin
        int s;
        int n;
        int l;
        coproc_pkg::pattern_t pat;
        for (int i = 0; i < MEM_WORDS; i++)
        begin
            mem[i] = {8'h61 + 8'($random(seed) & 3), 8'h61 + 8'($random(seed) & 3)};
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // early match, straddling patterns and one-char strings
        run_text(100, "xyabcdzzzzzz", "abcd");
        run_text(200, "qabqqq", "ab");
        run_text(240, "abcabdab", "abcd");
        run_text(260, "zzzzzab", "abc");
        run_text(280, "xaxbxaxbyc", "abc");
        run_text(300, "z", "q");
        run_text(302, "z", "z");
        run_text(320, "mnopqr", "qr");

        // random jobs over the random fill with memory stalls
        stall_en = 1'b1;
        for (int j = 0; j < NUM_RANDOM; j++)
        begin
            s = ($unsigned($random(seed)) % 2000) * 2;
            n = 1 + $unsigned($random(seed)) % MAX_STR;
            l = 1 + $unsigned($random(seed)) % `PATTERN_CHARS;
            pat = '0;
            for (int k = 0; k < l; k++)
            begin
                // 'e' never occurs in the fill so some jobs must miss
                pat[k*`CHAR_WIDTH +: `CHAR_WIDTH] = 8'h61 + 8'($unsigned($random(seed)) % 5);
            end
            run_job(s, s + n - 1, pat, l);
        end
        stall_en = 1'b0;

        // odd start and then end below start
        run_bad_job(101, 110);
        run_bad_job(400, 390);
        run_text(500, "recovery", "ove");

        assert (done_count == good_jobs)
            else report_mismatch("done pulse count differs from job count");
        $display("jobs %0d, done pulses %0d, errors %0d", good_jobs, done_count, errors);
        if (errors == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

    // jobs times string length times stall margin in clock periods
    initial
    begin
        #(NUM_JOBS * MAX_STR * STALL_MARGIN * PERIOD);
        $display("simulation ran past the watchdog limit");
        $display("tests failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
hw/coproc_pkg.sv
hw/text_fetcher.sv
hw/shift_and_matcher.sv
hw/job_control.sv
hw/coprocessor_top.sv
verification/tb_coprocessor.sv

/* Makefile */
# Verilator build and run of the string-match coprocessor testbench

VERILATOR ?= verilator
TOP       ?= tb_coprocessor
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := hw/coproc_settings.svh hw/coproc_pkg.sv hw/text_fetcher.sv \
           hw/shift_and_matcher.sv hw/job_control.sv hw/coprocessor_top.sv \
           verification/tb_coprocessor.sv

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
